//--- bench/lstm_state_unit_tb.sv
// Testbench for the cell-state update unit with table-driven runs checked against a Q4.12 model
`default_nettype none

module lstm_state_unit_tb;

  import lstm_fixed_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RUNS     = 10;
  // Cycles from the sampled answer to the next REQUEST entry
  localparam int ELEMENT_CYCLES = 8;
  // Gate value modes
  localparam int MODE_RAND = 0;
  localparam int MODE_SAT  = 1;
  localparam int MODE_ZERO = 2;

  ////////////////////////////////////////////////////////////
  // Run table with one row per START
  ////////////////////////////////////////////////////////////

  bit run_clear [NUM_RUNS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  int run_len   [NUM_RUNS] = '{16, 16, 5, 16, 8, 8, 1, 3, 16, 12};
  int run_mode  [NUM_RUNS] = '{MODE_RAND, MODE_RAND, MODE_RAND, MODE_RAND, MODE_SAT,
                               MODE_SAT, MODE_RAND, MODE_ZERO, MODE_RAND, MODE_RAND};

  logic                         CLK;
  logic                         RST;
  logic                         START;
  logic                         CLEAR_STATE;
  logic        [LEN_WIDTH-1:0]  SIZE_L_IN;
  logic                         IN_ENABLE;
  logic signed [DATA_WIDTH-1:0] I_IN;
  logic signed [DATA_WIDTH-1:0] F_IN;
  logic signed [DATA_WIDTH-1:0] A_IN;
  logic                         ELEMENT_REQUEST;
  logic                         S_OUT_ENABLE;
  logic signed [DATA_WIDTH-1:0] S_OUT;
  logic        [ADDR_WIDTH-1:0] S_INDEX_OUT;
  logic                         READY;
  logic                         BUSY;

  // Model of the state memory
  logic signed [DATA_WIDTH-1:0] model_state [MAX_LENGTH];
  // Expected results in output order
  logic signed [DATA_WIDTH-1:0] exp_data_q [$];
  int                           exp_index_q [$];
  bit                           exp_last_q [$];
  logic signed [DATA_WIDTH-1:0] want_data;
  int                           want_index;
  bit                           want_last;
  bit                           ready_due;
  int                           req_count;
  int                           out_count;
  integer                       seed;

  lstm_state_unit DUT (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .CLEAR_STATE     (CLEAR_STATE),
    .SIZE_L_IN       (SIZE_L_IN),
    .IN_ENABLE       (IN_ENABLE),
    .I_IN            (I_IN),
    .F_IN            (F_IN),
    .A_IN            (A_IN),
    .ELEMENT_REQUEST (ELEMENT_REQUEST),
    .S_OUT_ENABLE    (S_OUT_ENABLE),
    .S_OUT           (S_OUT),
    .S_INDEX_OUT     (S_INDEX_OUT),
    .READY           (READY),
    .BUSY            (BUSY)
  );

  always #CLK_HALF CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input longint expected, input longint actual);
    abort_run($sformatf("error at time %0t: %s expected %0d, got %0d",
                        $time, name, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////
  // Q4.12 reference arithmetic
  ////////////////////////////////////////////////////////////

  function automatic logic signed [DATA_WIDTH-1:0] saturate(input longint value);
    if (value > longint'(DATA_MAX)) begin
      return DATA_MAX;
    end else if (value < longint'(DATA_MIN)) begin
      return DATA_MIN;
    end
    return value[DATA_WIDTH-1:0];
  endfunction

  // Floor division by 2^FRAC_BITS and then clamp
  function automatic logic signed [DATA_WIDTH-1:0] mul_floor(
    input logic signed [DATA_WIDTH-1:0] x,
    input logic signed [DATA_WIDTH-1:0] y
  );
    longint full;
    longint scale;
    longint quotient;
    full     = longint'(x) * longint'(y);
    scale    = longint'(1) << FRAC_BITS;
    quotient = full / scale;
    // Division truncates toward zero so negative remainders step down
    if (full < 0 && (full % scale) != 0) begin
      quotient = quotient - 1;
    end
    return saturate(quotient);
  endfunction

  function automatic logic signed [DATA_WIDTH-1:0] add_sat(
    input logic signed [DATA_WIDTH-1:0] x,
    input logic signed [DATA_WIDTH-1:0] y
  );
    return saturate(longint'(x) + longint'(y));
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic pick_gates(input int mode, input int idx,
                            output logic signed [DATA_WIDTH-1:0] gi,
                            output logic signed [DATA_WIDTH-1:0] gf,
                            output logic signed [DATA_WIDTH-1:0] ga);
    int rnd;
    case (mode)
      // Products pinned to a bound and a repeat run clamps the sum too
      MODE_SAT: begin
        gf = DATA_MAX;
        ga = DATA_MAX;
        gi = (idx % 2 == 0) ? DATA_MAX : DATA_MIN;
      end
      MODE_ZERO: begin
        rnd = $random(seed);
        gi  = '0;
        gf  = '0;
        ga  = rnd[DATA_WIDTH-1:0];
      end
      default: begin
        rnd = $random(seed);
        gi  = rnd[DATA_WIDTH-1:0];
        rnd = $random(seed);
        gf  = rnd[DATA_WIDTH-1:0];
        rnd = $random(seed);
        ga  = rnd[DATA_WIDTH-1:0];
      end
    endcase
  endtask

  task automatic drive_answer(input logic signed [DATA_WIDTH-1:0] gi,
                              input logic signed [DATA_WIDTH-1:0] gf,
                              input logic signed [DATA_WIDTH-1:0] ga);
    IN_ENABLE <= 1'b1;
    I_IN      <= gi;
    F_IN      <= gf;
    A_IN      <= ga;
  endtask

  // One vector with an optional clear first and answers after 0 to 3 cycles
  task automatic run_vector(input bit do_clear, input int len, input int mode);
    logic signed [DATA_WIDTH-1:0] gi;
    logic signed [DATA_WIDTH-1:0] gf;
    logic signed [DATA_WIDTH-1:0] ga;
    logic signed [DATA_WIDTH-1:0] expected;
    int delay;
    int l;
    if (do_clear) begin
      CLEAR_STATE <= 1'b1;
      @(posedge CLK);
      CLEAR_STATE <= 1'b0;
      for (l = 0; l < MAX_LENGTH; l++) begin
        model_state[l] = '0;
      end
    end
    START     <= 1'b1;
    SIZE_L_IN <= LEN_WIDTH'(len);
    @(posedge CLK);
    START <= 1'b0;
    for (l = 0; l < len; l++) begin
      // DUT enters REQUEST on this edge
      pick_gates(mode, l, gi, gf, ga);
      expected       = add_sat(mul_floor(gf, model_state[l]), mul_floor(gi, ga));
      model_state[l] = expected;
      exp_data_q.push_back(expected);
      exp_index_q.push_back(l);
      exp_last_q.push_back(l == len - 1);
      delay = $unsigned($random(seed)) % 4;
      // Zero delay answers in the request cycle itself
      if (delay == 0) begin
        drive_answer(gi, gf, ga);
      end
      @(posedge CLK);
      assert (ELEMENT_REQUEST === 1'b1)
        else report_mismatch("ELEMENT_REQUEST", 1, ELEMENT_REQUEST);
      assert (BUSY === 1'b1) else report_mismatch("BUSY", 1, BUSY);
      if (delay != 0) begin
        repeat (delay - 1) @(posedge CLK);
        drive_answer(gi, gf, ga);
        @(posedge CLK);
      end
      IN_ENABLE <= 1'b0;
      if (l < len - 1) begin
        repeat (ELEMENT_CYCLES) @(posedge CLK);
      end
    end
    while (READY !== 1'b1) begin
      @(posedge CLK);
    end
    assert (BUSY === 1'b0) else report_mismatch("BUSY", 0, BUSY);
    assert (out_count == len) else report_mismatch("S_OUT_ENABLE count", len, out_count);
    assert (req_count == len) else report_mismatch("ELEMENT_REQUEST count", len, req_count);
    assert (exp_data_q.size() == 0) else abort_run("results missing at the end of a run");
    out_count = 0;
    req_count = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (RST === 1'b0) begin
      // READY only on the cycle after the final element
      assert (READY === ready_due) else report_mismatch("READY", ready_due, READY);
      ready_due = 1'b0;
      if (ELEMENT_REQUEST === 1'b1) begin
        req_count++;
      end
      if (S_OUT_ENABLE === 1'b1) begin
        assert (exp_data_q.size() != 0)
          else abort_run("S_OUT_ENABLE pulsed with no element outstanding");
        want_data  = exp_data_q.pop_front();
        want_index = exp_index_q.pop_front();
        want_last  = exp_last_q.pop_front();
        assert (S_OUT === want_data) else report_mismatch("S_OUT", want_data, S_OUT);
        assert (S_INDEX_OUT === want_index)
          else report_mismatch("S_INDEX_OUT", want_index, S_INDEX_OUT);
        ready_due = want_last;
        out_count++;
      end
    end
  end

  // Watchdog allows 20 cycles per element after reset
  initial begin
    longint limit;
    int total;
    int r;
    total = 0;
    for (r = 0; r < NUM_RUNS; r++) begin
      total += run_len[r];
    end
    limit = longint'(RESET_CYCLES + total * 20) * (2 * CLK_HALF);
    #(limit);
    abort_run("timeout: the DUT did not finish all runs in time");
  end

  initial begin
    int r;
    seed        = 33;
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    CLEAR_STATE = 1'b0;
    SIZE_L_IN   = '0;
    IN_ENABLE   = 1'b0;
    I_IN        = '0;
    F_IN        = '0;
    A_IN        = '0;
    ready_due   = 1'b0;
    req_count   = 0;
    out_count   = 0;
    // All entries read as zero out of reset
    for (r = 0; r < MAX_LENGTH; r++) begin
      model_state[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    assert (ELEMENT_REQUEST === 1'b0) else report_mismatch("ELEMENT_REQUEST", 0, ELEMENT_REQUEST);
    assert (S_OUT_ENABLE === 1'b0) else report_mismatch("S_OUT_ENABLE", 0, S_OUT_ENABLE);
    assert (READY === 1'b0) else report_mismatch("READY", 0, READY);
    assert (BUSY === 1'b0) else report_mismatch("BUSY", 0, BUSY);
    for (r = 0; r < NUM_RUNS; r++) begin
      run_vector(run_clear[r], run_len[r], run_mode[r]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/fixed_alu.sv
// Shared Q4.12 arithmetic unit, saturating multiply or add with one-cycle latency
`default_nettype none

module fixed_alu (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic                                       alu_start,
  input  lstm_ctrl_pkg::alu_op_t                     alu_op,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_a,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_b,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_result,
  output logic                                       alu_done
);

  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  // Full-width product and its Q4.12 alignment
  logic signed [2*DATA_WIDTH-1:0] product;
  logic signed [2*DATA_WIDTH-1:0] product_shifted;
  // One guard bit catches add overflow
  logic signed [DATA_WIDTH:0]     sum;
  logic signed [DATA_WIDTH-1:0]   result_next;

  ////////////////////////////////////////////////////////////
  // Combinational datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    product         = alu_a * alu_b;
    // Arithmetic shift, rounds toward minus infinity
    product_shifted = product >>> FRAC_BITS;
    sum             = alu_a + alu_b;
    case (alu_op)
      ALU_MUL: begin
        if (product_shifted > DATA_MAX) begin
          result_next = DATA_MAX;
        end else if (product_shifted < DATA_MIN) begin
          result_next = DATA_MIN;
        end else begin
          result_next = product_shifted[DATA_WIDTH-1:0];
        end
      end
      default: begin
        if (sum > DATA_MAX) begin
          result_next = DATA_MAX;
        end else if (sum < DATA_MIN) begin
          result_next = DATA_MIN;
        end else begin
          result_next = sum[DATA_WIDTH-1:0];
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  // Done strobe, exactly one cycle behind start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      alu_done <= 1'b0;
    end else begin
      alu_done <= alu_start;
    end
  end

  // Result holds until the next start
  always_ff @(posedge CLK) begin
    if (alu_start) begin
      alu_result <= result_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/lstm_ctrl_pkg.sv
// Sequencer states and arithmetic opcodes for the cell-state update unit
`default_nettype none

package lstm_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  // One pass per element, back to REQUEST until the last index
  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    FETCH,
    MUL_FS,
    MUL_IA,
    ADD_STATE,
    WRITE_BACK
  } gate_state_t;

  ////////////////////////////////////////////////////////////
  // Shared ALU opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    ALU_MUL,
    ALU_ADD
  } alu_op_t;

endpackage

`default_nettype wire

//--- logic/lstm_fixed_pkg.sv
// Fixed-point format and vector sizing for the cell-state update unit
`default_nettype none

package lstm_fixed_pkg;

  ////////////////////////////////////////////////////////////
  // Q4.12 element format
  ////////////////////////////////////////////////////////////

  // One signed element
  localparam int DATA_WIDTH = 16;
  // Fraction bits of Q4.12
  localparam int FRAC_BITS = 12;

  // Saturation bounds
  localparam logic signed [DATA_WIDTH-1:0] DATA_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam logic signed [DATA_WIDTH-1:0] DATA_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  ////////////////////////////////////////////////////////////
  // Vector sizing
  ////////////////////////////////////////////////////////////

  // Largest L
  localparam int MAX_LENGTH = 16;
  // Element index, 0 to MAX_LENGTH-1
  localparam int ADDR_WIDTH = 4;
  // Length value, up to MAX_LENGTH itself
  localparam int LEN_WIDTH = 5;

endpackage

`default_nettype wire

//--- logic/lstm_state_unit.sv
// Cell-state update unit top, sequencer with shared ALU, state buffer and output stage
`default_nettype none

module lstm_state_unit (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic                                       START,
  input  logic                                       CLEAR_STATE,
  input  logic        [lstm_fixed_pkg::LEN_WIDTH-1:0]  SIZE_L_IN,
  input  logic                                       IN_ENABLE,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] I_IN,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] F_IN,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] A_IN,
  output logic                                       ELEMENT_REQUEST,
  output logic                                       S_OUT_ENABLE,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] S_OUT,
  output logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] S_INDEX_OUT,
  output logic                                       READY,
  output logic                                       BUSY
);

  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  // Sequencer to ALU
  logic                         alu_start;
  alu_op_t                      alu_op;
  logic signed [DATA_WIDTH-1:0] alu_a;
  logic signed [DATA_WIDTH-1:0] alu_b;
  logic signed [DATA_WIDTH-1:0] alu_result;
  logic                         alu_done;

  // Sequencer to state memory
  logic                         clear;
  logic                         rd_en;
  logic        [ADDR_WIDTH-1:0] rd_addr;
  logic signed [DATA_WIDTH-1:0] rd_data;
  logic                         wr_en;
  logic        [ADDR_WIDTH-1:0] wr_addr;
  logic signed [DATA_WIDTH-1:0] wr_data;

  // Sequencer to output stage
  logic                         result_valid;
  logic signed [DATA_WIDTH-1:0] result_data;
  logic        [ADDR_WIDTH-1:0] result_index;
  logic                         result_last;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  state_gate_vector u_sequencer (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .CLEAR_STATE     (CLEAR_STATE),
    .SIZE_L_IN       (SIZE_L_IN),
    .IN_ENABLE       (IN_ENABLE),
    .I_IN            (I_IN),
    .F_IN            (F_IN),
    .A_IN            (A_IN),
    .ELEMENT_REQUEST (ELEMENT_REQUEST),
    .BUSY            (BUSY),
    .alu_start       (alu_start),
    .alu_op          (alu_op),
    .alu_a           (alu_a),
    .alu_b           (alu_b),
    .alu_result      (alu_result),
    .alu_done        (alu_done),
    .clear           (clear),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .result_valid    (result_valid),
    .result_data     (result_data),
    .result_index    (result_index),
    .result_last     (result_last)
  );

  // One ALU for both products and the sum
  fixed_alu u_alu (
    .CLK        (CLK),
    .RST        (RST),
    .alu_start  (alu_start),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .alu_done   (alu_done)
  );

  state_memory u_state_mem (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  state_output_stage u_output (
    .CLK          (CLK),
    .RST          (RST),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_index (result_index),
    .result_last  (result_last),
    .S_OUT_ENABLE (S_OUT_ENABLE),
    .S_OUT        (S_OUT),
    .S_INDEX_OUT  (S_INDEX_OUT),
    .READY        (READY)
  );

endmodule

`default_nettype wire

//--- logic/state_gate_vector.sv
// Sequencer for s = f*s_prev + i*a, one element at a time over the shared ALU
`default_nettype none

module state_gate_vector (
  input  logic                                       CLK,
  input  logic                                       RST,
  // Run control
  input  logic                                       START,
  input  logic                                       CLEAR_STATE,
  input  logic        [lstm_fixed_pkg::LEN_WIDTH-1:0]  SIZE_L_IN,
  // Gate element exchange
  input  logic                                       IN_ENABLE,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] I_IN,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] F_IN,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] A_IN,
  output logic                                       ELEMENT_REQUEST,
  output logic                                       BUSY,
  // ALU side
  output logic                                       alu_start,
  output lstm_ctrl_pkg::alu_op_t                     alu_op,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_a,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_b,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] alu_result,
  input  logic                                       alu_done,
  // State memory side
  output logic                                       clear,
  output logic                                       rd_en,
  output logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] rd_addr,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                                       wr_en,
  output logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] wr_addr,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] wr_data,
  // Output stage side
  output logic                                       result_valid,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] result_data,
  output logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] result_index,
  output logic                                       result_last
);

  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  gate_state_t state;
  // Second cycle of a two-cycle step, or request already pulsed
  logic phase;

  logic [ADDR_WIDTH-1:0] index;
  logic [ADDR_WIDTH-1:0] last_index;

  // Gate operands for the element in flight
  logic signed [DATA_WIDTH-1:0] i_reg;
  logic signed [DATA_WIDTH-1:0] f_reg;
  logic signed [DATA_WIDTH-1:0] a_reg;
  // f*s_prev held while i*a runs
  logic signed [DATA_WIDTH-1:0] fs_prod;

  logic at_last;

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      phase      <= 1'b0;
      index      <= '0;
      last_index <= '0;
    end else begin
      case (state)
        IDLE: begin
          phase <= 1'b0;
          if (START) begin
            index      <= '0;
            last_index <= ADDR_WIDTH'(SIZE_L_IN - 1'b1);
            state      <= REQUEST;
          end
        end
        // Wait here until the environment answers
        REQUEST: begin
          phase <= 1'b1;
          if (IN_ENABLE) begin
            phase <= 1'b0;
            state <= FETCH;
          end
        end
        // Memory read of s(t-1)
        FETCH: begin
          state <= MUL_FS;
        end
        MUL_FS: begin
          phase <= 1'b1;
          if (alu_done) begin
            phase <= 1'b0;
            state <= MUL_IA;
          end
        end
        MUL_IA: begin
          phase <= 1'b1;
          if (alu_done) begin
            phase <= 1'b0;
            state <= ADD_STATE;
          end
        end
        ADD_STATE: begin
          phase <= 1'b1;
          if (alu_done) begin
            phase <= 1'b0;
            state <= WRITE_BACK;
          end
        end
        WRITE_BACK: begin
          if (at_last) begin
            state <= IDLE;
          end else begin
            index <= index + 1'b1;
            state <= REQUEST;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  // Gates latched on the answer, read issued next cycle in FETCH
  always_ff @(posedge CLK) begin
    if (state == REQUEST && IN_ENABLE) begin
      i_reg <= I_IN;
      f_reg <= F_IN;
      a_reg <= A_IN;
    end
    if (state == MUL_FS && alu_done) begin
      fs_prod <= alu_result;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decoded strobes and datapath select
  ////////////////////////////////////////////////////////////

  assign at_last         = (index == last_index);
  assign BUSY            = (state != IDLE);
  // First cycle of REQUEST only
  assign ELEMENT_REQUEST = (state == REQUEST) && !phase;
  assign clear           = (state == IDLE) && CLEAR_STATE;

  assign rd_en   = (state == FETCH);
  assign rd_addr = index;

  // Start on the first cycle of each ALU step
  assign alu_start = !phase &&
                     (state == MUL_FS || state == MUL_IA || state == ADD_STATE);

  always_comb begin
    alu_op = ALU_MUL;
    alu_a  = '0;
    alu_b  = '0;
    case (state)
      MUL_FS: begin
        alu_a = f_reg;
        alu_b = rd_data;
      end
      MUL_IA: begin
        alu_a = i_reg;
        alu_b = a_reg;
      end
      // i*a still sits on the ALU result
      ADD_STATE: begin
        alu_op = ALU_ADD;
        alu_a  = fs_prod;
        alu_b  = alu_result;
      end
      default: begin
        alu_op = ALU_MUL;
      end
    endcase
  end

  // Write-back and hand-off in the same cycle
  assign wr_en        = (state == WRITE_BACK);
  assign wr_addr      = index;
  assign wr_data      = alu_result;
  assign result_valid = (state == WRITE_BACK);
  assign result_data  = alu_result;
  assign result_index = index;
  assign result_last  = (state == WRITE_BACK) && at_last;

endmodule

`default_nettype wire

//--- logic/state_memory.sv
// Cell-state buffer with per-entry valid flags, cleared entries read as zero
`default_nettype none

module state_memory (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic                                       clear,
  input  logic                                       rd_en,
  input  logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] rd_data,
  input  logic                                       wr_en,
  input  logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] wr_data
);

  import lstm_fixed_pkg::*;

  // State storage, one entry per element
  logic signed [DATA_WIDTH-1:0] mem [MAX_LENGTH];
  // Entry written since the last clear
  logic [MAX_LENGTH-1:0] valid;

  ////////////////////////////////////////////////////////////
  // Valid flags
  ////////////////////////////////////////////////////////////

  // Whole vector drops in one cycle on clear
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid <= '0;
    end else if (clear) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_addr] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage and synchronous read
  ////////////////////////////////////////////////////////////

  // Untouched entries keep old data across runs
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Stale data masked by the flag, so s(t-1) starts at zero
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      if (valid[rd_addr]) begin
        rd_data <= mem[rd_addr];
      end else begin
        rd_data <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/state_output_stage.sv
// Output register for new state elements and the end-of-vector READY pulse
`default_nettype none

module state_output_stage (
  input  logic                                       CLK,
  input  logic                                       RST,
  input  logic                                       result_valid,
  input  logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] result_data,
  input  logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] result_index,
  input  logic                                       result_last,
  output logic                                       S_OUT_ENABLE,
  output logic signed [lstm_fixed_pkg::DATA_WIDTH-1:0] S_OUT,
  output logic        [lstm_fixed_pkg::ADDR_WIDTH-1:0] S_INDEX_OUT,
  output logic                                       READY
);

  // Final element seen on the output this cycle
  logic last_out;

  ////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////

  // READY trails the final S_OUT_ENABLE by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      S_OUT_ENABLE <= 1'b0;
      last_out     <= 1'b0;
      READY        <= 1'b0;
    end else begin
      S_OUT_ENABLE <= result_valid;
      last_out     <= result_valid && result_last;
      READY        <= last_out;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data
  ////////////////////////////////////////////////////////////

  // Holds the last element between pulses
  always_ff @(posedge CLK) begin
    if (result_valid) begin
      S_OUT       <= result_data;
      S_INDEX_OUT <= result_index;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/lstm_fixed_pkg.sv
logic/lstm_ctrl_pkg.sv
logic/fixed_alu.sv
logic/state_memory.sv
logic/state_gate_vector.sv
logic/state_output_stage.sv
logic/lstm_state_unit.sv
bench/lstm_state_unit_tb.sv
